// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mul_16bit
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
source/mul_pkg.sv
source/booth_encoder.sv
source/wallace_reducer.sv
source/final_adder.sv
source/credit_counter.sv
source/pipe_ctrl.sv
source/mul_16bit_top.sv
sim/mul_16bit_asserts.sv
sim/tb_mul_16bit.sv

// ==== sim/mul_16bit_asserts.sv ====
// Multiplier handshake assertions
`timescale 1ns/1ps
`default_nettype none

module mul_16bit_asserts (
    input wire logic                          i_clk,
    input wire logic                          i_rst_n,
    input wire logic                          i_accept,
    input wire logic                          i_return,
    input wire logic [mul_pkg::CREDIT_W-1:0]  i_free,
    input wire logic                          i_out_valid
);

    // Each accept spends exactly one free credit.
    a_accept_takes_credit : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_accept && !i_return |=> int'(i_free) == int'($past(i_free)) - 1)
        else $error("accept did not take exactly one free credit");

    a_free_in_range : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        int'(i_free) <= mul_pkg::CREDITS)
        else $error("free credit count above its reset value");

    // Every result is an accept from PIPE_DEPTH edges before.
    a_fixed_latency : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_out_valid == $past(i_accept, mul_pkg::PIPE_DEPTH))
        else $error("output valid out of step with accept");

endmodule

bind mul_16bit_top mul_16bit_asserts u_asserts (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_accept    (w_accept),
    .i_return    (i_credit),
    .i_free      (w_free),
    .i_out_valid (o_valid)
);

`default_nettype wire

// ==== sim/tb_mul_16bit.sv ====
// Multiplier pipeline testbench
`timescale 1ns/1ps
`default_nettype none

module tb_mul_16bit;

    localparam int NROWS    = 16;
    localparam int WAIT_MAX = 60;

    // Columns are opcode, a, b and the expected product.
    localparam logic [65:0] TABLE [NROWS] = '{
        {mul_pkg::OP_SS, 16'h0000, 16'h1234, 32'h0000_0000},
        {mul_pkg::OP_SS, 16'h0001, 16'hFFFF, 32'hFFFF_FFFF},
        {mul_pkg::OP_SS, 16'hFFFF, 16'hFFFF, 32'h0000_0001},
        {mul_pkg::OP_SS, 16'h8000, 16'h8000, 32'h4000_0000},
        {mul_pkg::OP_UU, 16'h8000, 16'h8000, 32'h4000_0000},
        {mul_pkg::OP_SU, 16'h8000, 16'h8000, 32'hC000_0000},
        {mul_pkg::OP_UU, 16'hFFFF, 16'hFFFF, 32'hFFFE_0001},
        {mul_pkg::OP_UU, 16'h0001, 16'hFFFF, 32'h0000_FFFF},
        {mul_pkg::OP_SU, 16'hFFFF, 16'hFFFF, 32'hFFFF_0001},
        {mul_pkg::OP_SU, 16'h0003, 16'hFFFF, 32'h0002_FFFD},
        {mul_pkg::OP_SS, 16'h7FFF, 16'h8000, 32'hC000_8000},
        {mul_pkg::OP_SS, 16'h0064, 16'hFF9C, 32'hFFFF_D8F0},
        {mul_pkg::OP_UU, 16'h1234, 16'h5678, 32'h0626_0060},
        {mul_pkg::OP_SS, 16'hEDCC, 16'h5678, 32'hF9D9_FFA0},
        {mul_pkg::OP_SU, 16'h7FFF, 16'hFFFF, 32'h7FFE_8001},
        {mul_pkg::OP_SU, 16'h8001, 16'h0002, 32'hFFFF_0002}
    };

    logic                          clk = 1'b0;
    logic                          rst_n;
    logic                          valid;
    logic [mul_pkg::OPND_W-1:0]    a;
    logic [mul_pkg::OPND_W-1:0]    b;
    mul_pkg::mul_op_e              op;
    logic                          credit = 1'b0;
    logic                          ready;
    logic                          out_valid;
    logic [mul_pkg::PROD_W-1:0]    prod;
    logic                          idle;
    logic [mul_pkg::PROD_W-1:0]    exp_drv;
    logic                          credit_due = 1'b0;
    logic                          hold_credits;
    logic                          fast_credits;
    logic [31:0]                   lfsr = 32'h5d7129f5;
    logic [mul_pkg::PROD_W-1:0]    exp_q[$];
    int                            acc_q[$];
    int                            due_q[$];
    int                            acc_log[NROWS];
    int                            cycle = 0;
    int                            last_due = 0;
    int                            acc_cnt = 0;
    int                            out_cnt = 0;
    int                            ret_cnt = 0;
    int                            held = 0;
    int                            released = 0;
    int                            release_cnt = 0;
    int                            mon_errs = 0;
    int                            chk_errs = 0;
    int                            tmo_errs = 0;

    mul_16bit_top UUT (
        .i_clk    (clk),
        .i_rst_n  (rst_n),
        .i_valid  (valid),
        .i_a      (a),
        .i_b      (b),
        .i_op     (op),
        .i_credit (credit),
        .o_ready  (ready),
        .o_valid  (out_valid),
        .o_prod   (prod),
        .o_idle   (idle)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle  <= cycle + 1;
        credit <= credit_due;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    // Queue one credit pulse, 0 to 7 cycles out, never two on one edge.
    task automatic schedule_return(input logic now);
        logic [2:0] dly;
        int         due;
        dly = 3'd0;
        for (int k = 0; k < 3 && !now; k++) begin
            lfsr = lfsr_step(lfsr);
            dly  = {dly[1:0], lfsr[0]};
        end
        due = cycle + 1 + int'(dly);
        last_due = (due > last_due) ? due : last_due + 1;
        due_q.push_back(last_due);
    endtask

    // Scoreboard, latency check and consumer model.
    always @(negedge clk) begin : monitor
        logic [mul_pkg::PROD_W-1:0] exp_p;
        int                         acc_at;
        if (rst_n) begin
            // Accept cycle, closed by the coming rising edge.
            if (valid && ready) begin
                exp_q.push_back(exp_drv);
                acc_q.push_back(cycle);
                if (acc_cnt < NROWS) begin
                    acc_log[acc_cnt] = cycle;
                end
                acc_cnt++;
            end
            if (out_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Result at %0t has no pending operand pair", $time);
                    mon_errs++;
                end else begin
                    exp_p  = exp_q.pop_front();
                    acc_at = acc_q.pop_front();
                    if (prod !== exp_p) begin
                        $display("ERROR at %0t: o_prod got %h expected %h", $time, prod, exp_p);
                        mon_errs++;
                    end
                    if (cycle != acc_at + mul_pkg::PIPE_DEPTH) begin
                        $display("ERROR at %0t: o_valid cycle got %0d expected %0d",
                                 $time, cycle, acc_at + mul_pkg::PIPE_DEPTH);
                        mon_errs++;
                    end
                end
                out_cnt++;
                if (hold_credits) begin
                    held++;
                end else begin
                    schedule_return(fast_credits);
                end
            end
            if (released < release_cnt && held > 0) begin
                schedule_return(1'b1);
                released++;
                held--;
            end
            while (!hold_credits && held > 0) begin
                schedule_return(fast_credits);
                held--;
            end
            if (acc_cnt - ret_cnt > mul_pkg::CREDITS) begin
                $display("ERROR at %0t: outstanding results got %0d expected at most %0d",
                         $time, acc_cnt - ret_cnt, mul_pkg::CREDITS);
                mon_errs++;
            end
            credit_due = 1'b0;
            if (due_q.size() > 0 && due_q[0] <= cycle + 1) begin
                credit_due = 1'b1;
                due_q.delete(0);
                ret_cnt++;
            end
        end
    end

    task automatic drive_row(input int idx);
        valid   <= 1'b1;
        op      <= mul_pkg::mul_op_e'(TABLE[idx][65:64]);
        a       <= TABLE[idx][63:48];
        b       <= TABLE[idx][47:32];
        exp_drv <= TABLE[idx][31:0];
    endtask

    // Returns on the rising edge that takes the row.
    task automatic wait_accept(input int idx);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ready && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!ready) begin
            $display("Timeout: row %0d was never accepted", idx);
            tmo_errs++;
        end
        @(posedge clk);
    endtask

    task automatic send_row(input int idx);
        drive_row(idx);
        wait_accept(idx);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while ((out_cnt != acc_cnt || held != 0 || due_q.size() != 0) && waited < WAIT_MAX) begin
            @(posedge clk);
            waited++;
        end
        if (out_cnt != acc_cnt || held != 0 || due_q.size() != 0) begin
            $display("Timeout: results or credits still pending after drain");
            tmo_errs++;
        end
        repeat (2) @(posedge clk);
    endtask

    initial begin
        int first;
        int waited;
        rst_n        = 1'b0;
        valid        = 1'b0;
        a            = '0;
        b            = '0;
        op           = mul_pkg::OP_SS;
        exp_drv      = '0;
        hold_credits = 1'b0;
        fast_credits = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || ready !== 1'b1 || idle !== 1'b1) begin
            $display("ERROR at %0t: o_valid o_ready o_idle got %b%b%b expected 011",
                     $time, out_valid, ready, idle);
            chk_errs++;
        end

        // Credits come straight back.
        @(posedge clk);
        fast_credits = 1'b1;
        first = acc_cnt;
        for (int i = 0; i < 8; i++) begin
            send_row(i);
        end
        valid <= 1'b0;
        for (int i = 1; i < mul_pkg::CREDITS; i++) begin
            if (acc_log[first + i] != acc_log[first] + i) begin
                $display("ERROR at %0t: accept cycle got %0d expected %0d",
                         $time, acc_log[first + i], acc_log[first] + i);
                chk_errs++;
            end
        end
        wait_drained();

        // Credits withheld, so the fifth row must wait.
        hold_credits = 1'b1;
        for (int i = 8; i < 12; i++) begin
            send_row(i);
        end
        drive_row(12);
        repeat (8) begin
            @(negedge clk);
            if (ready !== 1'b0) begin
                $display("ERROR at %0t: o_ready got %b expected 0", $time, ready);
                chk_errs++;
            end
            if (idle !== 1'b0) begin
                $display("ERROR at %0t: o_idle got %b expected 0", $time, idle);
                chk_errs++;
            end
        end
        @(posedge clk);
        release_cnt++;
        wait_accept(12);
        hold_credits = 1'b0;
        fast_credits = 1'b0;

        for (int i = 13; i < NROWS; i++) begin
            send_row(i);
        end
        valid <= 1'b0;
        wait_drained();

        waited = 0;
        while (idle !== 1'b1 && waited < WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (idle !== 1'b1) begin
            $display("Timeout: o_idle did not return high after the drain");
            tmo_errs++;
        end

        $display("Errors: scoreboard %0d, checks %0d, timeouts %0d", mon_errs, chk_errs, tmo_errs);
        if (mon_errs + chk_errs + tmo_errs == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/booth_encoder.sv ====
// Radix-4 Booth row generator
`timescale 1ns/1ps
`default_nettype none

module booth_encoder (
    input  wire logic                                            i_clk,
    input  wire logic                                            i_rst_n,
    input  wire logic                                            i_load,
    input  wire logic [mul_pkg::OPND_W-1:0]                      i_a,
    input  wire logic [mul_pkg::OPND_W-1:0]                      i_b,
    input  wire mul_pkg::mul_op_e                                i_op,
    output logic [mul_pkg::ROWS-1:0][mul_pkg::PROD_W-1:0]        o_rows
);

    logic                                             w_a_sgn;
    logic                                             w_b_sgn;
    logic [mul_pkg::OPND_W:0]                         w_a_ext;
    logic [mul_pkg::OPND_W:0]                         w_b_ext;
    logic [mul_pkg::PROD_W-1:0]                       w_mcand;
    logic [mul_pkg::OPND_W+2:0]                       w_mplier;
    logic [mul_pkg::ROWS-1:0][mul_pkg::PROD_W-1:0]    w_rows;
    logic [mul_pkg::ROWS-1:0][mul_pkg::PROD_W-1:0]    r_rows;

    // Operand A is signed except in unsigned mode, B only in signed mode.
    assign w_a_sgn = (i_op != mul_pkg::OP_UU);
    assign w_b_sgn = (i_op == mul_pkg::OP_SS);

    assign w_a_ext = {w_a_sgn & i_a[mul_pkg::OPND_W-1], i_a};
    assign w_b_ext = {w_b_sgn & i_b[mul_pkg::OPND_W-1], i_b};

    // Multiplicand as a 32-bit two's complement value.
    assign w_mcand = {{(mul_pkg::PROD_W-mul_pkg::OPND_W-1){w_a_ext[mul_pkg::OPND_W]}}, w_a_ext};

    // Implicit zero below bit 0, one sign bit above the top group.
    assign w_mplier = {w_b_ext[mul_pkg::OPND_W], w_b_ext, 1'b0};

    for (genvar g = 0; g < mul_pkg::ROWS; g++) begin : gen_row
        logic [2:0]                 w_grp;
        logic                       w_one;
        logic                       w_two;
        logic                       w_neg;
        logic [mul_pkg::PROD_W-1:0] w_mag;
        logic [mul_pkg::PROD_W-1:0] w_val;

        assign w_grp = w_mplier[2*g +: 3];
        assign w_one = w_grp[1] ^ w_grp[0];
        assign w_two = (w_grp == 3'b011) || (w_grp == 3'b100);
        // 3'b111 encodes zero, so it must not negate.
        assign w_neg = w_grp[2] & ~(w_grp[1] & w_grp[0]);

        assign w_mag = w_two ? {w_mcand[mul_pkg::PROD_W-2:0], 1'b0} :
                       (w_one ? w_mcand : '0);
        // Invert and add one inside the row.
        assign w_val = (w_mag ^ {mul_pkg::PROD_W{w_neg}}) +
                       {{(mul_pkg::PROD_W-1){1'b0}}, w_neg};
        assign w_rows[g] = w_val << (2 * g);
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_rows <= '0;
        end else if (i_load) begin
            r_rows <= w_rows;
        end else begin
            // Empty slot carries zero rows.
            r_rows <= '0;
        end
    end

    assign o_rows = r_rows;

endmodule

`default_nettype wire

// ==== source/credit_counter.sv ====
// Output credit counter
`timescale 1ns/1ps
`default_nettype none

module credit_counter (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_take,
    input  wire logic                          i_return,
    output logic [mul_pkg::CREDIT_W-1:0]       o_free
);

    logic [mul_pkg::CREDIT_W-1:0] w_full;
    logic [mul_pkg::CREDIT_W-1:0] r_free;

    assign w_full = mul_pkg::CREDITS[mul_pkg::CREDIT_W-1:0];

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_free <= w_full;
        end else begin
            case ({i_take, i_return})
                2'b10: begin
                    r_free <= r_free - 1'b1;
                end
                2'b01: begin
                    // Extra return at full count is held.
                    if (r_free != w_full) begin
                        r_free <= r_free + 1'b1;
                    end
                end
                default: begin
                    r_free <= r_free;
                end
            endcase
        end
    end

    assign o_free = r_free;

endmodule

`default_nettype wire

// ==== source/final_adder.sv ====
// Carry-propagate product adder
`timescale 1ns/1ps
`default_nettype none

module final_adder (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic [mul_pkg::PROD_W-1:0]    i_sum,
    input  wire logic [mul_pkg::PROD_W-1:0]    i_carry,
    output logic [mul_pkg::PROD_W-1:0]         o_prod
);

    logic [mul_pkg::PROD_W-1:0] w_prod;
    logic [mul_pkg::PROD_W-1:0] r_prod;

    // Carry out of bit 31 is dropped.
    assign w_prod = i_sum + i_carry;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_prod <= '0;
        end else begin
            r_prod <= w_prod;
        end
    end

    assign o_prod = r_prod;

endmodule

`default_nettype wire

// ==== source/mul_16bit_top.sv ====
// Pipelined Booth-Wallace multiplier
`timescale 1ns/1ps
`default_nettype none

module mul_16bit_top (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_valid,
    input  wire logic [mul_pkg::OPND_W-1:0]    i_a,
    input  wire logic [mul_pkg::OPND_W-1:0]    i_b,
    input  wire mul_pkg::mul_op_e              i_op,
    input  wire logic                          i_credit,
    output logic                               o_ready,
    output logic                               o_valid,
    output logic [mul_pkg::PROD_W-1:0]         o_prod,
    output logic                               o_idle
);

    logic                                           w_accept;
    logic [mul_pkg::CREDIT_W-1:0]                   w_free;
    logic [mul_pkg::ROWS-1:0][mul_pkg::PROD_W-1:0]  w_rows;
    logic [mul_pkg::PROD_W-1:0]                     w_sum;
    logic [mul_pkg::PROD_W-1:0]                     w_carry;

    pipe_ctrl u_pipe_ctrl (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_valid     (i_valid),
        .i_free      (w_free),
        .o_ready     (o_ready),
        .o_accept    (w_accept),
        .o_out_valid (o_valid),
        .o_idle      (o_idle)
    );

    // One credit taken per accepted pair.
    credit_counter u_credit_counter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_take   (w_accept),
        .i_return (i_credit),
        .o_free   (w_free)
    );

    booth_encoder u_booth_encoder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_load  (w_accept),
        .i_a     (i_a),
        .i_b     (i_b),
        .i_op    (i_op),
        .o_rows  (w_rows)
    );

    wallace_reducer u_wallace_reducer (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_rows  (w_rows),
        .o_sum   (w_sum),
        .o_carry (w_carry)
    );

    final_adder u_final_adder (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_sum   (w_sum),
        .i_carry (w_carry),
        .o_prod  (o_prod)
    );

endmodule

`default_nettype wire

// ==== source/mul_pkg.sv ====
// Multiplier shared definitions
`default_nettype none

package mul_pkg;

    // Operand and product widths.
    localparam int OPND_W = 16;
    localparam int PROD_W = 32;

    // Radix-4 rows for a 17-bit multiplier.
    localparam int ROWS = 9;

    // Output credits and their counter width.
    localparam int CREDITS  = 4;
    localparam int CREDIT_W = 3;

    // Register stages from accept to result.
    localparam int PIPE_DEPTH = 3;

    typedef enum logic [1:0] {
        OP_SS = 2'd0,
        OP_UU = 2'd1,
        OP_SU = 2'd2
    } mul_op_e;

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_ACTIVE  = 2'd1,
        ST_BLOCKED = 2'd2
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== source/pipe_ctrl.sv ====
// Pipeline valid chain and FSM
`timescale 1ns/1ps
`default_nettype none

module pipe_ctrl (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_valid,
    input  wire logic [mul_pkg::CREDIT_W-1:0]  i_free,
    output logic                               o_ready,
    output logic                               o_accept,
    output logic                               o_out_valid,
    output logic                               o_idle
);

    logic [mul_pkg::PIPE_DEPTH-1:0] r_vchain;
    mul_pkg::ctrl_state_e           r_state;
    mul_pkg::ctrl_state_e           w_state_next;

    // Ready only while a result slot is reserved downstream.
    assign o_ready  = (i_free != '0);
    assign o_accept = i_valid & o_ready;

    // Valid bits move with the datapath registers.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_vchain <= '0;
        end else begin
            r_vchain <= {r_vchain[mul_pkg::PIPE_DEPTH-2:0], o_accept};
        end
    end

    assign o_out_valid = r_vchain[mul_pkg::PIPE_DEPTH-1];

    always_comb begin
        if (i_free == '0) begin
            w_state_next = mul_pkg::ST_BLOCKED;
        end else if (|r_vchain) begin
            w_state_next = mul_pkg::ST_ACTIVE;
        end else begin
            w_state_next = mul_pkg::ST_IDLE;
        end
    end

    // State follows counter and chain one cycle behind.
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state <= mul_pkg::ST_IDLE;
        end else begin
            r_state <= w_state_next;
        end
    end

    assign o_idle = (r_state == mul_pkg::ST_IDLE);

endmodule

`default_nettype wire

// ==== source/wallace_reducer.sv ====
// Wallace carry-save tree
`timescale 1ns/1ps
`default_nettype none

module wallace_reducer (
    input  wire logic                                         i_clk,
    input  wire logic                                         i_rst_n,
    input  wire logic [mul_pkg::ROWS-1:0][mul_pkg::PROD_W-1:0] i_rows,
    output logic [mul_pkg::PROD_W-1:0]                        o_sum,
    output logic [mul_pkg::PROD_W-1:0]                        o_carry
);

    // 3:2 compressor over full rows, carry in the upper half.
    function automatic logic [2*mul_pkg::PROD_W-1:0] csa(
        input logic [mul_pkg::PROD_W-1:0] a,
        input logic [mul_pkg::PROD_W-1:0] b,
        input logic [mul_pkg::PROD_W-1:0] c
    );
        logic [mul_pkg::PROD_W-1:0] s;
        logic [mul_pkg::PROD_W-1:0] cy;
        s  = a ^ b ^ c;
        cy = ((a & b) | (a & c) | (b & c)) << 1;
        return {cy, s};
    endfunction

    logic [5:0][mul_pkg::PROD_W-1:0] w_l1;
    logic [3:0][mul_pkg::PROD_W-1:0] w_l2;
    logic [2:0][mul_pkg::PROD_W-1:0] w_l3;
    logic [mul_pkg::PROD_W-1:0]      w_sum;
    logic [mul_pkg::PROD_W-1:0]      w_carry;
    logic [mul_pkg::PROD_W-1:0]      r_sum;
    logic [mul_pkg::PROD_W-1:0]      r_carry;

    // Nine rows to six.
    for (genvar g = 0; g < 3; g++) begin : gen_l1
        assign {w_l1[2*g+1], w_l1[2*g]} = csa(i_rows[3*g], i_rows[3*g+1], i_rows[3*g+2]);
    end

    // Six to four.
    assign {w_l2[1], w_l2[0]} = csa(w_l1[0], w_l1[1], w_l1[2]);
    assign {w_l2[3], w_l2[2]} = csa(w_l1[3], w_l1[4], w_l1[5]);

    // Four to three, one row passes through.
    assign {w_l3[1], w_l3[0]} = csa(w_l2[0], w_l2[1], w_l2[2]);
    assign w_l3[2] = w_l2[3];

    // Three to two.
    assign {w_carry, w_sum} = csa(w_l3[0], w_l3[1], w_l3[2]);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_sum   <= '0;
            r_carry <= '0;
        end else begin
            r_sum   <= w_sum;
            r_carry <= w_carry;
        end
    end

    assign o_sum   = r_sum;
    assign o_carry = r_carry;

endmodule

`default_nettype wire
